/* rtl/core_params.svh */
// core widths and instruction field positions for the RV32 decode stage
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data word and instruction
`define XLEN 32
`define ILEN 32

// register file, x0 counted
`define REG_IDX_W 5
`define NUM_REGS 32

// encoding field widths
`define OPC_W 7
`define F3_W 3
`define F7_W 7
`define ALU_OP_W 5

// field positions in the instruction word
`define OPC_RANGE 6:0
`define RD_RANGE 11:7
`define F3_RANGE 14:12
`define RS1_RANGE 19:15
`define RS2_RANGE 24:20
`define F7_RANGE 31:25

`endif

/* rtl/isa_pkg.sv */
// RV32 encoding types: major opcodes, funct values and ALU operations
`include "core_params.svh"

package isa_pkg;

	// major opcodes known to decode
	typedef enum logic [`OPC_W-1:0] {
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		OP_IMM = 7'b0010011,
		OP     = 7'b0110011,
		BRANCH = 7'b1100011
	} opcode_e;

	// funct3 for OP and OP-IMM
	localparam logic [`F3_W-1:0] F3_ADD_SUB = 3'b000;
	localparam logic [`F3_W-1:0] F3_SLL     = 3'b001;
	localparam logic [`F3_W-1:0] F3_SLT     = 3'b010;
	localparam logic [`F3_W-1:0] F3_SLTU    = 3'b011;
	localparam logic [`F3_W-1:0] F3_XOR     = 3'b100;
	localparam logic [`F3_W-1:0] F3_SRL_SRA = 3'b101;
	localparam logic [`F3_W-1:0] F3_OR      = 3'b110;
	localparam logic [`F3_W-1:0] F3_AND     = 3'b111;

	// funct3 for BRANCH
	localparam logic [`F3_W-1:0] F3_BEQ  = 3'b000;
	localparam logic [`F3_W-1:0] F3_BNE  = 3'b001;
	localparam logic [`F3_W-1:0] F3_BLT  = 3'b100;
	localparam logic [`F3_W-1:0] F3_BGE  = 3'b101;
	localparam logic [`F3_W-1:0] F3_BLTU = 3'b110;
	localparam logic [`F3_W-1:0] F3_BGEU = 3'b111;

	localparam logic [`F7_W-1:0] F7_BASE = 7'b0000000;
	localparam logic [`F7_W-1:0] F7_ALT  = 7'b0100000; // sub and sra

	// operation handed to execute, NOP is the reset value
	typedef enum logic [`ALU_OP_W-1:0] {
		NOP = 5'd0,
		ADD, SUB, SLT, SLTU, AND, OR, XOR, SLL, SRL, SRA,
		BEQ, BNE, BLT, BGE, BLTU, BGEU
	} alu_op_e;

endpackage

/* rtl/pipe_pkg.sv */
// bundles passed between the decode stage and its neighbours
`include "core_params.svh"

package pipe_pkg;

	// register write, used for writeback and for the execute result
	typedef struct packed {
		logic                  valid;
		logic [`REG_IDX_W-1:0] idx;
		logic [`XLEN-1:0]      data;
	} reg_wr_t;

	// decoded instruction as seen by execute
	typedef struct packed {
		isa_pkg::alu_op_e      op;
		logic [`XLEN-1:0]      src1;
		logic [`XLEN-1:0]      src2;   // imm already folded in when used
		logic [`XLEN-1:0]      imm;    // branch offset for execute
		logic [`REG_IDX_W-1:0] rd;
		logic                  rd_wr;
		logic [`XLEN-1:0]      pc;
		logic                  illegal;
	} dec_bundle_t;

endpackage

/* rtl/instr_decoder.sv */
// instruction decoder: field split, ALU or branch operation and immediate
`timescale 1ns/100ps
`include "core_params.svh"

module instr_decoder (
	input  logic [`ILEN-1:0]      instr,
	output isa_pkg::alu_op_e      op,
	output logic [`XLEN-1:0]      imm,
	output logic [`REG_IDX_W-1:0] rs1,
	output logic [`REG_IDX_W-1:0] rs2,
	output logic [`REG_IDX_W-1:0] rd,
	output logic                  rd_wr,
	output logic                  use_pc,
	output logic                  use_imm,
	output logic                  no_rs1,
	output logic                  illegal
);
	import isa_pkg::*;

	opcode_e          opcode;
	logic [`F3_W-1:0] funct3;
	logic [`F7_W-1:0] funct7;
	logic [`XLEN-1:0] imm_i;
	logic [`XLEN-1:0] imm_b;
	logic [`XLEN-1:0] imm_u;

	// funct7 only matters for the register form, except on shifts
	function automatic alu_op_e alu_decode(input logic [`F3_W-1:0] f3,
		input logic [`F7_W-1:0] f7, input logic reg_form);
		logic base;
		base = !reg_form || (f7 == F7_BASE);
		alu_decode = NOP;
		case (f3)
			F3_ADD_SUB: alu_decode = base ? ADD : ((f7 == F7_ALT) ? SUB : NOP);
			F3_SRL_SRA: alu_decode = (f7 == F7_BASE) ? SRL : ((f7 == F7_ALT) ? SRA : NOP);
			F3_SLL:     alu_decode = base ? SLL : NOP;
			F3_SLT:     alu_decode = base ? SLT : NOP;
			F3_SLTU:    alu_decode = base ? SLTU : NOP;
			F3_XOR:     alu_decode = base ? XOR : NOP;
			F3_OR:      alu_decode = base ? OR : NOP;
			F3_AND:     alu_decode = base ? AND : NOP;
			default:    alu_decode = NOP;
		endcase
	endfunction

	function automatic alu_op_e branch_decode(input logic [`F3_W-1:0] f3);
		case (f3)
			F3_BEQ:  branch_decode = BEQ;
			F3_BNE:  branch_decode = BNE;
			F3_BLT:  branch_decode = BLT;
			F3_BGE:  branch_decode = BGE;
			F3_BLTU: branch_decode = BLTU;
			F3_BGEU: branch_decode = BGEU;
			default: branch_decode = NOP;  // 010 and 011 undefined
		endcase
	endfunction

	assign opcode = opcode_e'(instr[`OPC_RANGE]);
	assign funct3 = instr[`F3_RANGE];
	assign funct7 = instr[`F7_RANGE];
	assign rs1    = instr[`RS1_RANGE];
	assign rs2    = instr[`RS2_RANGE];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};

	always_comb
	begin
		op      = NOP;
		imm     = '0;
		rd_wr   = 1'b0;
		use_pc  = 1'b0;
		use_imm = 1'b0;
		no_rs1  = 1'b0;
		illegal = 1'b0;
		case (opcode)
			LUI:
			begin
				op      = ADD;  // 0 + imm
				imm     = imm_u;
				rd_wr   = 1'b1;
				use_imm = 1'b1;
				no_rs1  = 1'b1;
			end
			AUIPC:
			begin
				op      = ADD;
				imm     = imm_u;
				rd_wr   = 1'b1;
				use_pc  = 1'b1;
				use_imm = 1'b1;
			end
			OP_IMM:
			begin
				op      = alu_decode(funct3, funct7, 1'b0);
				imm     = imm_i;
				rd_wr   = (op != NOP);
				use_imm = 1'b1;
			end
			OP:
			begin
				op    = alu_decode(funct3, funct7, 1'b1);
				rd_wr = (op != NOP);
			end
			BRANCH:
			begin
				op  = branch_decode(funct3);
				imm = imm_b;    // rs2 stays on src2
			end
			default:
			begin
				// bubble with zero operands
				illegal = 1'b1;
				no_rs1  = 1'b1;
				use_imm = 1'b1;
			end
		endcase
	end

	assign rd = rd_wr ? instr[`RD_RANGE] : '0;

endmodule

/* rtl/reg_file.sv */
// general register file x1..x31 with two combinational reads and one write
`timescale 1ns/100ps
`include "core_params.svh"

module reg_file (
	input  logic                  cpu_clk,
	input  logic                  cpu_rstn,
	input  pipe_pkg::reg_wr_t     wr,
	input  logic [`REG_IDX_W-1:0] rs1,
	input  logic [`REG_IDX_W-1:0] rs2,
	output logic [`XLEN-1:0]      rdata1,
	output logic [`XLEN-1:0]      rdata2
);

	// no storage behind x0
	logic [`XLEN-1:0] regs [1:`NUM_REGS-1];

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			for (int i = 1; i < `NUM_REGS; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wr.valid && (wr.idx != '0))
		begin
			regs[wr.idx] <= wr.data;
		end
	end

	// same-cycle writeback data comes through operand_forward
	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* rtl/operand_forward.sv */
// source operand selection with execute and writeback forwarding
`timescale 1ns/100ps
`include "core_params.svh"

module operand_forward (
	input  isa_pkg::alu_op_e      op,
	input  logic [`XLEN-1:0]      imm,
	input  logic [`REG_IDX_W-1:0] rd,
	input  logic                  rd_wr,
	input  logic                  illegal,
	input  logic [`REG_IDX_W-1:0] rs1,
	input  logic [`REG_IDX_W-1:0] rs2,
	input  logic                  use_pc,
	input  logic                  use_imm,
	input  logic                  no_rs1,
	input  logic [`XLEN-1:0]      pc,
	input  logic [`XLEN-1:0]      rdata1,
	input  logic [`XLEN-1:0]      rdata2,
	input  logic                  ex_valid,
	input  pipe_pkg::dec_bundle_t ex_bundle,
	input  pipe_pkg::reg_wr_t     ex_result,
	input  pipe_pkg::reg_wr_t     wb_wr,
	output pipe_pkg::dec_bundle_t bundle
);

	logic [`XLEN-1:0] fwd1;
	logic [`XLEN-1:0] fwd2;

	// x0, then execute, then writeback, then the register file
	function automatic logic [`XLEN-1:0] pick(input logic [`REG_IDX_W-1:0] idx,
		input logic [`XLEN-1:0] rf_data);
		logic ex_hit;
		logic wb_hit;
		ex_hit = ex_valid && ex_bundle.rd_wr && (ex_bundle.rd == idx) &&
			ex_result.valid && (ex_result.idx == idx);
		wb_hit = wb_wr.valid && (wb_wr.idx == idx);
		if (idx == '0)
			pick = '0;
		else if (ex_hit)
			pick = ex_result.data;
		else if (wb_hit)
			pick = wb_wr.data;
		else
			pick = rf_data;
	endfunction

	always_comb
	begin
		fwd1 = pick(rs1, rdata1);
		fwd2 = pick(rs2, rdata2);
	end

	always_comb
	begin
		bundle.op      = op;
		bundle.src1    = use_pc ? pc : (no_rs1 ? '0 : fwd1); // auipc / lui
		bundle.src2    = use_imm ? imm : fwd2;
		bundle.imm     = imm;
		bundle.rd      = rd;
		bundle.rd_wr   = rd_wr;
		bundle.pc      = pc;
		bundle.illegal = illegal;
	end

endmodule

/* rtl/dec_ex_reg.sv */
// decode to execute pipeline register with valid/ready and flush
`timescale 1ns/100ps
`include "core_params.svh"

module dec_ex_reg (
	input  logic                  cpu_clk,
	input  logic                  cpu_rstn,
	input  logic                  in_valid,
	input  pipe_pkg::dec_bundle_t in_bundle,
	output logic                  in_ready,
	input  logic                  flush,
	output logic                  out_valid,
	output pipe_pkg::dec_bundle_t out_bundle,
	input  logic                  out_ready
);

	logic load;

	// single entry, refills in the cycle it drains
	assign in_ready = out_ready || !out_valid;
	assign load     = in_valid && in_ready && !flush;

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			out_valid <= 1'b0;
		end
		else if (flush)
		begin
			out_valid <= 1'b0;   // mispredict wins over a transfer
		end
		else if (in_ready)
		begin
			out_valid <= in_valid;
		end
	end

	// held under back-pressure
	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			out_bundle <= '0;
		end
		else if (load)
		begin
			out_bundle <= in_bundle;
		end
	end

endmodule

/* rtl/dec_stage.sv */
// RV32 decode stage top: decoder, register file, forwarding and execute buffer
`timescale 1ns/100ps
`include "core_params.svh"

module dec_stage (
	input  logic                  cpu_clk,
	input  logic                  cpu_rstn,
	input  logic                  if_valid,
	input  logic [`ILEN-1:0]      instr,
	input  logic [`XLEN-1:0]      pc,
	output logic                  dec_ready,
	output logic                  ex_valid,
	output pipe_pkg::dec_bundle_t ex_bundle,
	input  logic                  ex_ready,
	input  pipe_pkg::reg_wr_t     ex_result,
	input  pipe_pkg::reg_wr_t     wb_wr,
	input  logic                  flush
);
	import isa_pkg::*;
	import pipe_pkg::*;

	alu_op_e               op;
	logic [`XLEN-1:0]      imm;
	logic [`REG_IDX_W-1:0] rs1;
	logic [`REG_IDX_W-1:0] rs2;
	logic [`REG_IDX_W-1:0] rd;
	logic                  rd_wr;
	logic                  use_pc;
	logic                  use_imm;
	logic                  no_rs1;
	logic                  illegal;
	logic [`XLEN-1:0]      rdata1;
	logic [`XLEN-1:0]      rdata2;
	dec_bundle_t           bundle; // decoded, not yet registered

	instr_decoder decoder_i (
		.instr   (instr),
		.op      (op),
		.imm     (imm),
		.rs1     (rs1),
		.rs2     (rs2),
		.rd      (rd),
		.rd_wr   (rd_wr),
		.use_pc  (use_pc),
		.use_imm (use_imm),
		.no_rs1  (no_rs1),
		.illegal (illegal)
	);

	reg_file reg_file_i (
		.cpu_clk  (cpu_clk),
		.cpu_rstn (cpu_rstn),
		.wr       (wb_wr),
		.rs1      (rs1),
		.rs2      (rs2),
		.rdata1   (rdata1),
		.rdata2   (rdata2)
	);

	operand_forward forward_i (
		.op        (op),
		.imm       (imm),
		.rd        (rd),
		.rd_wr     (rd_wr),
		.illegal   (illegal),
		.rs1       (rs1),
		.rs2       (rs2),
		.use_pc    (use_pc),
		.use_imm   (use_imm),
		.no_rs1    (no_rs1),
		.pc        (pc),
		.rdata1    (rdata1),
		.rdata2    (rdata2),
		.ex_valid  (ex_valid),
		.ex_bundle (ex_bundle),
		.ex_result (ex_result),
		.wb_wr     (wb_wr),
		.bundle    (bundle)
	);

	dec_ex_reg dec_ex_reg_i (
		.cpu_clk    (cpu_clk),
		.cpu_rstn   (cpu_rstn),
		.in_valid   (if_valid),
		.in_bundle  (bundle),
		.in_ready   (dec_ready),
		.flush      (flush),
		.out_valid  (ex_valid),
		.out_bundle (ex_bundle),
		.out_ready  (ex_ready)
	);

endmodule

/* verif/dec_stage_checker.sv */
// handshake and flush assertions bound into the decode stage
`timescale 1ns/100ps

module dec_stage_checker (
	input logic                  cpu_clk,
	input logic                  cpu_rstn,
	input logic                  flush,
	input logic                  dec_ready,
	input logic                  ex_valid,
	input logic                  ex_ready,
	input pipe_pkg::dec_bundle_t ex_bundle
);

	int fail_count = 0;  // failed assertions so far

	// bundle must not move while execute stalls
	bundle_held: assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
		ex_valid && !ex_ready |=> $stable(ex_bundle))
		else
		begin
			$error("ex_bundle changed while execute held it back");
			fail_count++;
		end

	flush_clears: assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
		flush |=> !ex_valid)
		else
		begin
			$error("ex_valid still high on the cycle after flush");
			fail_count++;
		end

	ready_rule: assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
		dec_ready == (ex_ready || !ex_valid))
		else
		begin
			$error("dec_ready differs from ex_ready or not ex_valid");
			fail_count++;
		end

endmodule

bind dec_stage dec_stage_checker checker_i (
	.cpu_clk   (cpu_clk),
	.cpu_rstn  (cpu_rstn),
	.flush     (flush),
	.dec_ready (dec_ready),
	.ex_valid  (ex_valid),
	.ex_ready  (ex_ready),
	.ex_bundle (ex_bundle)
);

/* verif/dec_stage_tb.sv */
// decode stage testbench driving a random instruction stream against a reference model
`timescale 1ns/100ps
`include "core_params.svh"

module dec_stage_tb;
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int NUM_INSTR      = 300;
	localparam int TIMEOUT_CYCLES = NUM_INSTR * 4 + 100;

	// op by funct3 with funct7 zero and branch op by funct3
	localparam alu_op_e BASE_OPS [8] = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
	localparam alu_op_e BR_OPS [8]   = '{BEQ, BNE, NOP, NOP, BLT, BGE, BLTU, BGEU};

	logic             cpu_clk;
	logic             cpu_rstn;
	logic             if_valid;
	logic [`ILEN-1:0] instr;
	logic [`XLEN-1:0] pc;
	logic             dec_ready;
	logic             ex_valid;
	dec_bundle_t      ex_bundle;
	logic             ex_ready;
	reg_wr_t          ex_result;
	reg_wr_t          wb_wr;
	logic             flush;

	logic [`XLEN-1:0] model_rf [`NUM_REGS];
	logic             model_valid;  // buffer entry as the model sees it
	dec_bundle_t      model_bundle;
	dec_bundle_t      exp_q [$];
	logic             hold;         // fetch stalled on the same instruction
	logic [`XLEN-1:0] next_pc;
	int               accepted;
	int               consumed;
	int               flushed;
	int               mismatches;
	int               other_errs;
	int               assert_errs;
	int               cycles;

	dec_stage dec_stage_i (
		.cpu_clk   (cpu_clk),
		.cpu_rstn  (cpu_rstn),
		.if_valid  (if_valid),
		.instr     (instr),
		.pc        (pc),
		.dec_ready (dec_ready),
		.ex_valid  (ex_valid),
		.ex_bundle (ex_bundle),
		.ex_ready  (ex_ready),
		.ex_result (ex_result),
		.wb_wr     (wb_wr),
		.flush     (flush)
	);

	initial
	begin
		cpu_clk = 1'b0;
		forever #2 cpu_clk = ~cpu_clk;
	end

	// low registers half of the time so forwarding paths get hit
	function automatic logic [`REG_IDX_W-1:0] pick_idx();
		if ($urandom_range(1) != 0)
			return 5'($urandom_range(7));
		return 5'($urandom_range(31));
	endfunction

	function automatic logic [`ILEN-1:0] gen_instr();
		logic [`ILEN-1:0] w;
		logic [6:0]       opc;
		int               kind;
		w        = $urandom();
		w[11:7]  = pick_idx();
		w[19:15] = pick_idx();
		w[24:20] = pick_idx();
		kind     = $urandom_range(11);
		case (kind)
			0: w[6:0] = LUI;
			1: w[6:0] = AUIPC;
			2, 3, 4:
			begin
				w[6:0] = OP_IMM;
				if (w[14:12] == 3'b001)
					w[31:25] = 7'h00;
				else if (w[14:12] == 3'b101)
					w[31:25] = ($urandom_range(1) != 0) ? 7'h20 : 7'h00;
			end
			5, 6, 7:
			begin
				w[6:0] = OP;
				if ($urandom_range(7) != 0)  // otherwise keep an odd funct7
					w[31:25] = ($urandom_range(1) != 0) ? 7'h20 : 7'h00;
			end
			8, 9: w[6:0] = BRANCH;
			default:
			begin
				opc = 7'($urandom());
				while (opc inside {LUI, AUIPC, OP_IMM, OP, BRANCH})
					opc = 7'($urandom());
				w[6:0] = opc;
			end
		endcase
		return w;
	endfunction

	function automatic alu_op_e alu_expect(input logic [2:0] f3, input logic [6:0] f7,
		input logic reg_form);
		alu_op_e op;
		op = BASE_OPS[f3];
		if (f3 == 3'b101 && f7 == 7'h20)
			op = SRA;
		else if (f3 == 3'b101 && f7 != 7'h00)
			op = NOP;
		else if (reg_form && f3 == 3'b000 && f7 == 7'h20)
			op = SUB;
		else if (reg_form && f7 != 7'h00)
			op = NOP;
		return op;
	endfunction

	function automatic logic [`XLEN-1:0] fwd_value(input logic [`REG_IDX_W-1:0] idx,
		input logic [`XLEN-1:0] rf [`NUM_REGS], input logic ex_v, input dec_bundle_t ex_b,
		input reg_wr_t ex_r, input reg_wr_t wb);
		logic [`XLEN-1:0] v;
		v = rf[idx];
		if (wb.valid && wb.idx == idx)
			v = wb.data;
		if (ex_v && ex_b.rd_wr && ex_b.rd == idx && ex_r.valid && ex_r.idx == idx)
			v = ex_r.data;  // execute is younger than writeback
		if (idx == '0)
			v = '0;
		return v;
	endfunction

	function automatic dec_bundle_t expected_bundle(input logic [`ILEN-1:0] ins,
		input logic [`XLEN-1:0] pc_v, input logic [`XLEN-1:0] rf [`NUM_REGS],
		input logic ex_v, input dec_bundle_t ex_b, input reg_wr_t ex_r, input reg_wr_t wb);
		dec_bundle_t      b;
		logic [`XLEN-1:0] s1;
		logic [`XLEN-1:0] s2;
		s1   = fwd_value(ins[19:15], rf, ex_v, ex_b, ex_r, wb);
		s2   = fwd_value(ins[24:20], rf, ex_v, ex_b, ex_r, wb);
		b    = '0;
		b.pc = pc_v;
		case (ins[6:0])
			LUI, AUIPC:
			begin
				b.op    = ADD;
				b.imm   = {ins[31:12], 12'h000};
				b.src1  = (ins[6:0] == AUIPC) ? pc_v : '0;
				b.src2  = b.imm;
				b.rd_wr = 1'b1;
			end
			OP_IMM:
			begin
				b.imm  = {{20{ins[31]}}, ins[31:20]};
				b.src1 = s1;
				b.src2 = b.imm;
				b.op   = alu_expect(ins[14:12], ins[31:25], 1'b0);
			end
			OP:
			begin
				b.src1 = s1;
				b.src2 = s2;
				b.op   = alu_expect(ins[14:12], ins[31:25], 1'b1);
			end
			BRANCH:
			begin
				b.imm  = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
				b.src1 = s1;
				b.src2 = s2;
				b.op   = BR_OPS[ins[14:12]];
			end
			default:
				b.illegal = 1'b1;  // bubble with zero operands
		endcase
		if (ins[6:0] == OP_IMM || ins[6:0] == OP)
			b.rd_wr = (b.op != NOP);
		if (b.rd_wr)
			b.rd = ins[11:7];
		return b;
	endfunction

	task automatic check_bundle(input dec_bundle_t got, input dec_bundle_t exp);
		if (got !== exp)
		begin
			mismatches++;
			$display("mismatch at %0t: ex_bundle got %h expected %h", $time, got, exp);
			$display("  op %s / %s, src1 %h / %h, src2 %h / %h, rd %0d / %0d",
				got.op.name(), exp.op.name(), got.src1, exp.src1, got.src2, exp.src2,
				got.rd, exp.rd);
		end
	endtask

	task automatic check_flag(input string sig, input logic got, input logic exp);
		if (got !== exp)
		begin
			mismatches++;
			$display("mismatch at %0t: %s got %b expected %b", $time, sig, got, exp);
		end
	endtask

	// one clock of drive, prediction and flag check before the model advances
	task automatic run_cycle(input logic fetch_on, input logic busy, input int init_idx);
		dec_bundle_t exp_b;
		logic        exp_ready;
		logic        acc;
		@(negedge cpu_clk);
		if (!hold)
		begin
			if_valid = fetch_on && ($urandom_range(3) != 0);
			if (if_valid)
			begin
				instr   = gen_instr();
				pc      = next_pc;
				next_pc = next_pc + 32'd4;
			end
		end
		ex_ready        = !busy || ($urandom_range(9) < 7);
		flush           = busy && ($urandom_range(24) == 0);
		ex_result.valid = ($urandom_range(7) != 0);
		ex_result.idx   = ($urandom_range(3) != 0) ? model_bundle.rd : pick_idx();
		ex_result.data  = $urandom();
		wb_wr.valid     = (init_idx >= 0) || ($urandom_range(1) != 0);
		wb_wr.idx       = (init_idx >= 0) ? 5'(init_idx) : pick_idx();
		wb_wr.data      = $urandom();
		exp_b = expected_bundle(instr, pc, model_rf, model_valid, model_bundle,
			ex_result, wb_wr);
		exp_ready = ex_ready || !model_valid;
		acc       = if_valid && exp_ready && !flush;
		if (flush && model_valid)
		begin
			void'(exp_q.pop_front());  // mispredicted so it never reaches execute
			flushed++;
		end
		if (acc)
		begin
			exp_q.push_back(exp_b);
			accepted++;
		end
		hold = if_valid && !acc;
		#1;
		check_flag("dec_ready", dec_ready, exp_ready);
		check_flag("ex_valid", ex_valid, model_valid);
		@(posedge cpu_clk);
		if (wb_wr.valid && wb_wr.idx != '0)
			model_rf[wb_wr.idx] = wb_wr.data;
		if (flush)
			model_valid = 1'b0;
		else if (exp_ready)
			model_valid = if_valid;
		if (acc)
			model_bundle = exp_b;
	endtask

	// execute side transfers in order
	initial
	begin
		forever
		begin
			@(posedge cpu_clk);
			if (ex_valid && ex_ready && !flush)
			begin
				if (exp_q.size() == 0)
				begin
					other_errs++;
					$display("at %0t execute took a bundle that was never accepted", $time);
				end
				else
					check_bundle(ex_bundle, exp_q.pop_front());
				consumed++;
			end
		end
	end

	initial
	begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES)
		begin
			@(posedge cpu_clk);
			cycles++;
		end
		$display("timeout: run still busy after %0d cycles", cycles);
		$display("Errors found");
		$finish;
	end

	initial
	begin
		void'($urandom(10));
		cpu_rstn     = 1'b0;
		if_valid     = 1'b0;
		instr        = '0;
		pc           = '0;
		ex_ready     = 1'b0;
		ex_result    = '0;
		wb_wr        = '0;
		flush        = 1'b0;
		model_valid  = 1'b0;
		model_bundle = '0;
		hold         = 1'b0;
		next_pc      = 32'h0000_1000;
		accepted     = 0;
		consumed     = 0;
		flushed      = 0;
		mismatches   = 0;
		other_errs   = 0;
		assert_errs  = 0;
		for (int i = 0; i < `NUM_REGS; i++)
			model_rf[i] = '0;
		repeat (5) @(posedge cpu_clk);
		@(negedge cpu_clk);
		check_flag("ex_valid", ex_valid, 1'b0);  // still in reset
		check_flag("dec_ready", dec_ready, 1'b1);
		check_bundle(ex_bundle, '0);
		cpu_rstn = 1'b1;
		for (int i = 0; i < `NUM_REGS; i++)
			run_cycle(1'b0, 1'b0, i);  // fill through writeback including x0
		while (accepted < NUM_INSTR)
			run_cycle(1'b1, 1'b1, -1);
		while (exp_q.size() != 0 || hold)
			run_cycle(1'b0, 1'b0, -1);
		repeat (2)
			run_cycle(1'b0, 1'b0, -1);
		if (accepted != consumed + flushed)
		begin
			other_errs++;
			$display("%0d instructions accepted, but %0d reached execute and %0d were flushed",
				accepted, consumed, flushed);
		end
		assert_errs = dec_stage_i.checker_i.fail_count;
		$display("mismatches %0d, other errors %0d, assertion failures %0d (%0d accepted, %0d flushed)",
			mismatches, other_errs, assert_errs, accepted, flushed);
		if (mismatches == 0 && other_errs == 0 && assert_errs == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* build.f */
+incdir+rtl
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/instr_decoder.sv
rtl/reg_file.sv
rtl/operand_forward.sv
rtl/dec_ex_reg.sv
rtl/dec_stage.sv
verif/dec_stage_checker.sv
verif/dec_stage_tb.sv

/* Makefile */
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= dec_stage_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Errors found

SOURCES := $(shell grep -v '^+' $(FILELIST)) rtl/core_params.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "simulator exited with status $$status"; exit 1; fi
	@if grep -q -e "$(FAIL_MSG)" -e "%Error" $(LOG); then echo "FAIL, see $(LOG)"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
